/* include/keystream_params.svh */
// Sizing macros for the keystream unit
// KS_FIFO_DEPTH must be a power of two and larger than KS_ROUNDS + 1
// Counter block layout assumes KS_BLOCK_W = 128 and KS_IV_W = 64
`ifndef KEYSTREAM_PARAMS_SVH
`define KEYSTREAM_PARAMS_SVH

// Parallel lanes per request
`define KS_LANES 4

// Mixing rounds, one pipeline stage each
`define KS_ROUNDS 12

// Payload buffer entries
`define KS_FIFO_DEPTH 16

// Lane block and key width
`define KS_BLOCK_W 128

// IV width, upper half of each counter block
`define KS_IV_W 64

`endif

/* design/keystream_pkg.sv */
// Vector types shared by the keystream RTL and its testbench
// Widths follow the macros in keystream_params.svh

`include "keystream_params.svh"

package keystream_pkg;

    // ------------------------------------------------------------------------
    // Data path vectors
    // ------------------------------------------------------------------------

    // One lane block, also the key width
    typedef logic [`KS_BLOCK_W-1:0] block_t;

    // All lanes side by side, lane 0 in the low bits
    typedef logic [`KS_LANES*`KS_BLOCK_W-1:0] wideBlock_t;

    // Request IV
    typedef logic [`KS_IV_W-1:0] iv_t;

    // ------------------------------------------------------------------------
    // Control vectors
    // ------------------------------------------------------------------------

    // Request sequence number, wraps silently
    typedef logic [31:0] reqCount_t;

    // Payload buffer index
    typedef logic [$clog2(`KS_FIFO_DEPTH)-1:0] fifoPtr_t;

endpackage

/* design/ctrBlockGen.sv */
// Producer stage, one cycle from reqValid to blkValid
// A key strobe in the same cycle as a request applies to that request
`timescale 1ns/1ps
`include "keystream_params.svh"

module ctrBlockGen (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   keyValid,
    input  keystream_pkg::block_t  keyIn,
    input  logic                   reqValid,
    input  keystream_pkg::iv_t     ivIn,
    output logic                   blkValid,
    output keystream_pkg::wideBlock_t blkData,
    output keystream_pkg::block_t  blkKey,
    output keystream_pkg::reqCount_t  blkSeq
);
    import keystream_pkg::*;

    block_t     keyReg;
    block_t     keyNow;
    reqCount_t  seqCount;
    wideBlock_t ctrBlocks;

    // Bypass so a fresh key reaches a same-cycle request
    assign keyNow = keyValid ? keyIn : keyReg;

    // Counter blocks: IV, sequence, lane index
    for (genvar lane = 0; lane < `KS_LANES; lane++) begin : gLane
        assign ctrBlocks[lane*`KS_BLOCK_W +: `KS_BLOCK_W] = {ivIn, seqCount, 32'(lane)};
    end

    // ------------------------------------------------------------------------
    // Key register and sequence counter
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            keyReg   <= '0;
            seqCount <= '0;
            blkValid <= 1'b0;
        end else begin
            if (keyValid) begin
                keyReg <= keyIn;
            end
            // One count per request
            if (reqValid) begin
                seqCount <= seqCount + 1'b1;
            end
            blkValid <= reqValid;
        end
    end

    // Payload of the stage, only loaded on a request
    always_ff @(posedge Clock) begin
        if (reqValid) begin
            blkData <= ctrBlocks;
            blkKey  <= keyNow;
            blkSeq  <= seqCount;
        end
    end

endmodule

/* design/mixPipeline.sv */
// Twelve-stage keyed mixing pipeline, padValid follows blkValid by KS_ROUNDS
// Key and sequence ride along with each item, so key changes never touch
// items already in flight
`timescale 1ns/1ps
`include "keystream_params.svh"

module mixPipeline (
    input  logic                      Clock,
    input  logic                      arstN,
    input  logic                      blkValid,
    input  keystream_pkg::wideBlock_t blkData,
    input  keystream_pkg::block_t     blkKey,
    input  keystream_pkg::reqCount_t  blkSeq,
    output logic                      padValid,
    output keystream_pkg::wideBlock_t padData,
    output keystream_pkg::reqCount_t  padSeq
);
    import keystream_pkg::*;

    // Left rotate per round
    localparam int RotAmount = 5;

    // Slot 0 is the pipeline input, slot r the output of round r
    logic [`KS_ROUNDS:0] stageValid;
    wideBlock_t          stageData [`KS_ROUNDS+1];
    block_t              stageKey  [`KS_ROUNDS+1];
    reqCount_t           stageSeq  [`KS_ROUNDS+1];

    // ------------------------------------------------------------------------
    // Round step, same on every lane
    // ------------------------------------------------------------------------
    function automatic wideBlock_t mixRound(
        input wideBlock_t  state,
        input block_t      key,
        input logic [7:0]  roundNum
    );
        wideBlock_t result;
        block_t     lane;
        for (int i = 0; i < `KS_LANES; i++) begin
            lane = state[i*`KS_BLOCK_W +: `KS_BLOCK_W] ^ key;
            lane = (lane << RotAmount) | (lane >> (`KS_BLOCK_W - RotAmount));
            // Round number into the low byte
            lane[7:0] = lane[7:0] ^ roundNum;
            result[i*`KS_BLOCK_W +: `KS_BLOCK_W] = lane;
        end
        return result;
    endfunction

    // Feed slot 0 straight from the producer
    assign stageValid[0] = blkValid;
    assign stageData[0]  = blkData;
    assign stageKey[0]   = blkKey;
    assign stageSeq[0]   = blkSeq;

    // ------------------------------------------------------------------------
    // Stage registers, every stage may hold an item
    // ------------------------------------------------------------------------
    for (genvar r = 1; r <= `KS_ROUNDS; r++) begin : gStage

        always_ff @(posedge Clock or negedge arstN) begin
            if (!arstN) begin
                stageValid[r] <= 1'b0;
            end else begin
                stageValid[r] <= stageValid[r-1];
            end
        end

        // Data moves only with a valid item
        always_ff @(posedge Clock) begin
            if (stageValid[r-1]) begin
                stageData[r] <= mixRound(stageData[r-1], stageKey[r-1], 8'(r));
                stageKey[r]  <= stageKey[r-1];
                stageSeq[r]  <= stageSeq[r-1];
            end
        end

    end

    // Last round is the pad
    assign padValid = stageValid[`KS_ROUNDS];
    assign padData  = stageData[`KS_ROUNDS];
    assign padSeq   = stageSeq[`KS_ROUNDS];

endmodule

/* design/payloadFifo.sv */
// Circular payload buffer, write visible on the next cycle
// Depth must be a power of two so the pointers wrap on their own
// No overflow or underflow guard, fixed latency keeps occupancy in range
`timescale 1ns/1ps
`include "keystream_params.svh"

module payloadFifo (
    input  logic                      Clock,
    input  logic                      arstN,
    input  logic                      wrEn,
    input  keystream_pkg::wideBlock_t wrData,
    input  logic                      rdEn,
    output keystream_pkg::wideBlock_t rdData,
    output logic                      empty
);
    import keystream_pkg::*;

    // Storage, no reset
    wideBlock_t mem [`KS_FIFO_DEPTH];

    fifoPtr_t wrPtr;
    fifoPtr_t rdPtr;

    // One extra bit so a full buffer is distinct from empty
    logic [$clog2(`KS_FIFO_DEPTH):0] count;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous read and write leaves count alone
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write port
    always_ff @(posedge Clock) begin
        if (wrEn) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Read is combinational from the head
    assign rdData = mem[rdPtr];

    // Only watched by the bound checks
    assign empty = (count == '0);

endmodule

/* design/padCombiner.sv */
// Output register, XORs the pad with its buffered payload
// Result and sequence hold until the next valid, outValid pulses one cycle
`timescale 1ns/1ps

module padCombiner (
    input  logic                      Clock,
    input  logic                      arstN,
    input  logic                      padValid,
    input  keystream_pkg::wideBlock_t padData,
    input  keystream_pkg::reqCount_t  padSeq,
    input  keystream_pkg::wideBlock_t payload,
    output logic                      outValid,
    output keystream_pkg::wideBlock_t outData,
    output keystream_pkg::reqCount_t  outSeq
);
    import keystream_pkg::*;

    wideBlock_t xorResult;

    // Pad and payload, all lanes at once
    assign xorResult = padData ^ payload;

    // Valid pulse
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= padValid;
        end
    end

    // Held result
    always_ff @(posedge Clock) begin
        if (padValid) begin
            outData <= xorResult;
            outSeq  <= padSeq;
        end
    end

endmodule

/* design/keystreamTop.sv */
// Counter-mode keystream unit, reqValid to outValid in exactly 14 cycles
// Single-cycle request strobe, no back-pressure, results in request order
// Up to 14 requests in flight, the payload buffer is sized to cover them
`timescale 1ns/1ps

module keystreamTop (
    input  logic                      Clock,
    input  logic                      arstN,
    input  logic                      keyValid,
    input  keystream_pkg::block_t     keyIn,
    input  logic                      reqValid,
    input  keystream_pkg::iv_t        ivIn,
    input  keystream_pkg::wideBlock_t payloadIn,
    output logic                      outValid,
    output keystream_pkg::wideBlock_t outData,
    output keystream_pkg::reqCount_t  outSeq
);
    import keystream_pkg::*;

    // Producer to pipeline
    logic       blkValid;
    wideBlock_t blkData;
    block_t     blkKey;
    reqCount_t  blkSeq;

    // Pipeline to consumer
    logic       padValid;
    wideBlock_t padData;
    reqCount_t  padSeq;

    // Buffer head
    wideBlock_t fifoData;

    // ------------------------------------------------------------------------
    // Counter block producer, 1 cycle
    // ------------------------------------------------------------------------
    ctrBlockGen uCtrBlockGen (
        .Clock    (Clock),
        .arstN    (arstN),
        .keyValid (keyValid),
        .keyIn    (keyIn),
        .reqValid (reqValid),
        .ivIn     (ivIn),
        .blkValid (blkValid),
        .blkData  (blkData),
        .blkKey   (blkKey),
        .blkSeq   (blkSeq)
    );

    // ------------------------------------------------------------------------
    // Mixing pipeline, KS_ROUNDS cycles
    // ------------------------------------------------------------------------
    mixPipeline uMixPipeline (
        .Clock    (Clock),
        .arstN    (arstN),
        .blkValid (blkValid),
        .blkData  (blkData),
        .blkKey   (blkKey),
        .blkSeq   (blkSeq),
        .padValid (padValid),
        .padData  (padData),
        .padSeq   (padSeq)
    );

    // Payload written with the request, popped with the pad
    // Empty flag left open, only the bound checks look at it
    payloadFifo uPayloadFifo (
        .Clock  (Clock),
        .arstN  (arstN),
        .wrEn   (reqValid),
        .wrData (payloadIn),
        .rdEn   (padValid),
        .rdData (fifoData),
        .empty  ()
    );

    // Output stage, 1 cycle
    padCombiner uPadCombiner (
        .Clock    (Clock),
        .arstN    (arstN),
        .padValid (padValid),
        .padData  (padData),
        .padSeq   (padSeq),
        .payload  (fifoData),
        .outValid (outValid),
        .outData  (outData),
        .outSeq   (outSeq)
    );

endmodule

/* verification/keystream_properties.sv */
// Bound checks for the payload buffer and the mixing pipeline
// Bound twice, unused inputs of each binding are tied off
`timescale 1ns/1ps
`include "keystream_params.svh"

module keystream_properties (
    input logic                            Clock,
    input logic                            arstN,
    input logic                            wrEn,
    input logic                            rdEn,
    input logic                            empty,
    input logic [$clog2(`KS_FIFO_DEPTH):0] count,
    input logic                            blkValid,
    input logic                            padValid
);

    // Failure tally, read back by the testbench at the end
    int unsigned violations = 0;

    // ------------------------------------------------------------------------
    // Payload buffer
    // ------------------------------------------------------------------------

    // Pop only with something stored
    aNoReadEmpty: assert property (@(posedge Clock) disable iff (!arstN)
        rdEn |-> !empty)
        else begin
            violations++;
            $error("payload buffer read while empty");
        end

    // Push only with a free entry
    aNoWriteFull: assert property (@(posedge Clock) disable iff (!arstN)
        wrEn |-> (count != `KS_FIFO_DEPTH))
        else begin
            violations++;
            $error("payload buffer written while full");
        end

    // ------------------------------------------------------------------------
    // Pipeline latency
    // ------------------------------------------------------------------------
    aPadAfterBlk: assert property (@(posedge Clock) disable iff (!arstN)
        blkValid |-> ##(`KS_ROUNDS) padValid)
        else begin
            violations++;
            $error("padValid missing KS_ROUNDS cycles after blkValid");
        end

    // No pad without a matching block
    aBlkBeforePad: assert property (@(posedge Clock) disable iff (!arstN)
        padValid |-> $past(blkValid, `KS_ROUNDS))
        else begin
            violations++;
            $error("padValid without blkValid KS_ROUNDS cycles earlier");
        end

endmodule

bind payloadFifo keystream_properties uFifoChecks (
    .Clock    (Clock),
    .arstN    (arstN),
    .wrEn     (wrEn),
    .rdEn     (rdEn),
    .empty    (empty),
    .count    (count),
    .blkValid (1'b0),
    .padValid (1'b0)
);

bind mixPipeline keystream_properties uPipeChecks (
    .Clock    (Clock),
    .arstN    (arstN),
    .wrEn     (1'b0),
    .rdEn     (1'b0),
    .empty    (1'b0),
    .count    ('0),
    .blkValid (blkValid),
    .padValid (padValid)
);

/* verification/keystreamTb.sv */
// Directed testbench for keystreamTop with a reference model and a watchdog
// Every result must arrive exactly 14 cycles after its request
`timescale 1ns/1ps
`include "keystream_params.svh"

module keystreamTb;
    import keystream_pkg::*;

    localparam int ClockPeriod    = 10;
    localparam int Latency        = `KS_ROUNDS + 2;
    localparam int MaxGap         = 12;
    localparam int NumTests       = 6;
    localparam int TotalRequests  = 1 + 20 + 10 + 3 + 8 + 7;
    // Requests with worst-case gaps plus a drain and idle margin per test
    localparam int WatchdogCycles = TotalRequests * MaxGap + NumTests * (Latency + 30) + 50;

    logic       Clock;
    logic       arstN;
    logic       keyValid;
    block_t     keyIn;
    logic       reqValid;
    iv_t        ivIn;
    wideBlock_t payloadIn;
    logic       outValid;
    wideBlock_t outData;
    reqCount_t  outSeq;

    // Model state and expected results
    int         seed = 32'h53ac_c774;
    int         cycleCount = 0;
    block_t     modelKey;
    reqCount_t  modelSeq;
    wideBlock_t expData[$];
    reqCount_t  expSeq[$];
    int         expCycle[$];

    keystreamTop DUT (
        .Clock     (Clock),
        .arstN     (arstN),
        .keyValid  (keyValid),
        .keyIn     (keyIn),
        .reqValid  (reqValid),
        .ivIn      (ivIn),
        .payloadIn (payloadIn),
        .outValid  (outValid),
        .outData   (outData),
        .outSeq    (outSeq)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // ------------------------------------------------------------------------
    // Reporting and checks
    // ------------------------------------------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkWide(input string name, input wideBlock_t expected,
                             input wideBlock_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic checkSeq(input string name, input reqCount_t expected,
                            input reqCount_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("FAILED %s expected %h got %h", name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model and random data
    // ------------------------------------------------------------------------

    // Counter blocks through all rounds, lane 0 in the low bits
    function automatic wideBlock_t padFor(input iv_t iv, input reqCount_t seq, input block_t key);
        wideBlock_t pad;
        block_t     blk;
        for (int lane = 0; lane < `KS_LANES; lane++) begin
            blk = {iv, seq, lane[31:0]};
            for (int r = 1; r <= `KS_ROUNDS; r++) begin
                blk = blk ^ key;
                // Rotate left by 5
                blk = {blk[`KS_BLOCK_W-6:0], blk[`KS_BLOCK_W-1:`KS_BLOCK_W-5]};
                blk[7:0] = blk[7:0] ^ r[7:0];
            end
            pad[lane*`KS_BLOCK_W +: `KS_BLOCK_W] = blk;
        end
        return pad;
    endfunction

    function automatic wideBlock_t randWide();
        wideBlock_t w;
        for (int i = 0; i < `KS_LANES * `KS_BLOCK_W / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    // Random key, one lane wide
    function automatic block_t randBlock();
        block_t b;
        for (int i = 0; i < `KS_BLOCK_W / 32; i++) begin
            b[i*32 +: 32] = $random(seed);
        end
        return b;
    endfunction

    function automatic iv_t randIv();
        return {$random(seed), $random(seed)};
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // One cycle of inputs, expected result queued for a request
    task automatic issue(input logic withReq, input iv_t iv, input wideBlock_t pay,
                         input logic withKey, input block_t key);
        @(posedge Clock);
        keyValid  <= withKey;
        keyIn     <= key;
        reqValid  <= withReq;
        ivIn      <= iv;
        payloadIn <= pay;
        // Same-cycle key applies to this request
        if (withKey) begin
            modelKey = key;
        end
        if (withReq) begin
            expData.push_back(padFor(iv, modelSeq, modelKey) ^ pay);
            expSeq.push_back(modelSeq);
            expCycle.push_back(cycleCount + 1 + Latency);
            modelSeq = modelSeq + 1;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge Clock);
            reqValid <= 1'b0;
            keyValid <= 1'b0;
        end
    endtask

    // Wait for every queued result with a bound
    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expData.size() > 0) begin
            idleCycles(1);
            waited++;
            if (waited > Latency + 10) begin
                abortRun("outstanding results did not arrive in time");
            end
        end
        idleCycles(2);
    endtask

    // ------------------------------------------------------------------------
    // Output monitor on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge Clock) begin
        cycleCount = cycleCount + 1;
        if (arstN) begin
            if (outValid) begin
                if (expData.size() == 0) begin
                    abortRun("outValid went high with no request outstanding");
                end else begin
                    if (cycleCount != expCycle[0]) begin
                        abortRun($sformatf("result %0d arrived at cycle %0d instead of %0d",
                                           expSeq[0], cycleCount, expCycle[0]));
                    end
                    checkWide("outData", expData[0], outData);
                    checkSeq("outSeq", expSeq[0], outSeq);
                    void'(expData.pop_front());
                    void'(expSeq.pop_front());
                    void'(expCycle.pop_front());
                end
            end else if (expCycle.size() > 0 && cycleCount >= expCycle[0]) begin
                abortRun($sformatf("outValid missing for request %0d", expSeq[0]));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    // Quiet after reset then one zero-payload request
    task automatic testIdleAndSingle();
        idleCycles(20);
        issue(1'b1, randIv(), '0, 1'b0, '0);
        waitDrain();
    endtask

    // Requests on 20 consecutive cycles
    task automatic testBackToBack();
        for (int i = 0; i < 20; i++) begin
            issue(1'b1, 64'h0123_4567_89ab_cdef, '0, 1'b0, '0);
        end
        waitDrain();
    endtask

    task automatic testRandomPayload();
        issue(1'b0, '0, '0, 1'b1, randBlock());
        for (int i = 0; i < 10; i++) begin
            issue(1'b1, randIv(), randWide(), 1'b0, '0);
        end
        waitDrain();
    endtask

    // Keys change while earlier requests are in flight
    task automatic testKeyChange();
        issue(1'b0, '0, '0, 1'b1, randBlock());
        issue(1'b1, randIv(), randWide(), 1'b0, '0);
        issue(1'b1, randIv(), randWide(), 1'b1, randBlock());
        issue(1'b0, '0, '0, 1'b1, randBlock());
        issue(1'b1, randIv(), randWide(), 1'b0, '0);
        waitDrain();
    endtask

    task automatic testSparse();
        int gap;
        for (int i = 0; i < 8; i++) begin
            issue(1'b1, randIv(), randWide(), 1'b0, '0);
            gap = 1 + ($unsigned($random(seed)) % MaxGap);
            idleCycles(gap);
        end
        waitDrain();
    endtask

    // Reset drops in-flight items and restarts the sequence
    task automatic testResetMidStream();
        for (int i = 0; i < 6; i++) begin
            issue(1'b1, randIv(), randWide(), 1'b0, '0);
        end
        idleCycles(5);
        @(posedge Clock);
        arstN    <= 1'b0;
        reqValid <= 1'b0;
        keyValid <= 1'b0;
        expData.delete();
        expSeq.delete();
        expCycle.delete();
        modelSeq = '0;
        modelKey = '0;
        repeat (2) @(posedge Clock);
        arstN <= 1'b1;
        // Monitor flags any stale outValid here
        idleCycles(20);
        issue(1'b1, randIv(), randWide(), 1'b0, '0);
        waitDrain();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        Clock     = 1'b0;
        arstN     = 1'b0;
        keyValid  = 1'b0;
        keyIn     = '0;
        reqValid  = 1'b0;
        ivIn      = '0;
        payloadIn = '0;
        modelKey  = '0;
        modelSeq  = '0;
        repeat (2) @(posedge Clock);
        arstN <= 1'b1;

        testIdleAndSingle();
        testBackToBack();
        testRandomPayload();
        testKeyChange();
        testSparse();
        testResetMidStream();

        if (DUT.uPayloadFifo.uFifoChecks.violations != 0 ||
            DUT.uMixPipeline.uPipeChecks.violations != 0) begin
            abortRun("bound assertions reported violations");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(WatchdogCycles * ClockPeriod);
        abortRun("watchdog timeout, the run did not finish");
    end

endmodule

/* flist.f */
+incdir+include
design/keystream_pkg.sv
design/ctrBlockGen.sv
design/mixPipeline.sv
design/payloadFifo.sv
design/padCombiner.sv
design/keystreamTop.sv
verification/keystream_properties.sv
verification/keystreamTb.sv

/* Bender.yml */
package:
  name: keystream

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/keystream_pkg.sv
      - design/ctrBlockGen.sv
      - design/mixPipeline.sv
      - design/payloadFifo.sv
      - design/padCombiner.sv
      - design/keystreamTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/keystream_properties.sv
      - verification/keystreamTb.sv
